/* bench/exec_stage_props.sv */
`timescale 1ns/1ps

module exec_stage_props import exec_pkg::*; (
    input logic  CLK,
    input logic  rst_n,
    input logic  reg_w_en,
    input logic  mem_r_en,
    input logic  mem_w_en,
    input logic  jmp_do,
    input word_t jmp_pc
);

    a_load_store_excl: assert property (@(posedge CLK) disable iff (!rst_n)
        !(mem_r_en && mem_w_en))
        else $error("mem_r_en and mem_w_en high in the same cycle");

    a_wb_store_excl: assert property (@(posedge CLK) disable iff (!rst_n)
        !(reg_w_en && mem_w_en))
        else $error("reg_w_en and mem_w_en high in the same cycle");

    // targets are halfword aligned at least
    a_jmp_aligned: assert property (@(posedge CLK) disable iff (!rst_n)
        jmp_do |-> !jmp_pc[0])
        else $error("jmp_pc bit 0 set while jmp_do is high");

    a_reset_idle: assert property (@(posedge CLK)
        !rst_n |=> !(reg_w_en || mem_r_en || mem_w_en || jmp_do))
        else $error("request enable high in the cycle after reset");

endmodule

bind exec_stage exec_stage_props i_exec_stage_props (
    .CLK      (CLK),
    .rst_n    (rst_n),
    .reg_w_en (reg_w_en),
    .mem_r_en (mem_r_en),
    .mem_w_en (mem_w_en),
    .jmp_do   (jmp_do),
    .jmp_pc   (jmp_pc)
);

/* bench/exec_stage_tb.sv */
`timescale 1ns/1ps

module exec_stage_tb import exec_pkg::*; ();

    localparam int    CLK_HALF   = 20;     // 40 ns period
    localparam int    DRIVE_DLY  = 2;
    localparam int    RESET_CYC  = 5;
    localparam string TRACE_FILE = "bench/exec_trace.txt";

    typedef struct {
        logic [3:0] ctl;        // mem_wait, stall, flush
        word_t      pc;
        logic [6:0] opcode;
        logic [2:0] funct3;
        logic [6:0] funct7;
        reg_addr_t  rd;
        word_t      rs1;
        word_t      rs2;
        word_t      imm;
        logic [7:0] flags;      // signed, jmp, mem_w, mem_r, reg_w
        reg_addr_t  exp_rd;
        word_t      exp_data;
        word_t      exp_addr;
        strb_t      exp_strb;
    } trace_line_t;

    logic       CLK = 1'b0;
    logic       rst_n;
    logic       flush;
    logic       stall;
    logic       mem_wait;
    word_t      pc;
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    reg_addr_t  rd_addr;
    word_t      rs1_data;
    word_t      rs2_data;
    word_t      imm;
    logic       reg_w_en;
    reg_addr_t  reg_w_rd;
    word_t      reg_w_data;
    logic       mem_r_en;
    reg_addr_t  mem_r_rd;
    word_t      mem_r_addr;
    strb_t      mem_r_strb;
    logic       mem_r_signed;
    logic       mem_w_en;
    word_t      mem_w_addr;
    strb_t      mem_w_strb;
    word_t      mem_w_data;
    logic       jmp_do;
    word_t      jmp_pc;

    trace_line_t trace[$];
    int          errors       = 0;
    int          failed_tests = 0;
    int          cycles       = 0;
    int          cycle_limit  = 0;
    logic        test_bad;

    exec_stage i_exec_stage (
        .CLK          (CLK),
        .rst_n        (rst_n),
        .flush        (flush),
        .stall        (stall),
        .mem_wait     (mem_wait),
        .pc           (pc),
        .opcode       (opcode),
        .funct3       (funct3),
        .funct7       (funct7),
        .rd_addr      (rd_addr),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .imm          (imm),
        .reg_w_en     (reg_w_en),
        .reg_w_rd     (reg_w_rd),
        .reg_w_data   (reg_w_data),
        .mem_r_en     (mem_r_en),
        .mem_r_rd     (mem_r_rd),
        .mem_r_addr   (mem_r_addr),
        .mem_r_strb   (mem_r_strb),
        .mem_r_signed (mem_r_signed),
        .mem_w_en     (mem_w_en),
        .mem_w_addr   (mem_w_addr),
        .mem_w_strb   (mem_w_strb),
        .mem_w_data   (mem_w_data),
        .jmp_do       (jmp_do),
        .jmp_pc       (jmp_pc)
    );

    always #CLK_HALF CLK = ~CLK;

    always @(posedge CLK) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("timeout after %0d cycles, the trace did not finish", cycles);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    task automatic load_trace();
        int          fd;
        int          n;
        string       text;
        trace_line_t t;
        fd = $fopen(TRACE_FILE, "r");
        if (fd == 0) begin
            $display("cannot open trace file %s", TRACE_FILE);
            errors++;
            return;
        end
        while (!$feof(fd)) begin
            text = "";
            n = $fgets(text, fd);
            if (n > 0 && text.len() > 1 && text[0] != 8'h23) begin   // skip # lines
                n = $sscanf(text, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                            t.ctl, t.pc, t.opcode, t.funct3, t.funct7, t.rd, t.rs1,
                            t.rs2, t.imm, t.flags, t.exp_rd, t.exp_data, t.exp_addr,
                            t.exp_strb);
                if (n == 14) begin
                    trace.push_back(t);
                end else begin
                    $display("malformed trace line, only %0d fields: %s", n, text);
                    errors++;
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic check_word(input string what, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
            test_bad = 1'b1;
        end
    endtask

    task automatic check_reg(input string what, input reg_addr_t got, input reg_addr_t exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
            test_bad = 1'b1;
        end
    endtask

    task automatic check_strb(input string what, input strb_t got, input strb_t exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s is %b, expected %b", $time, what, got, exp);
            errors++;
            test_bad = 1'b1;
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s is %b, expected %b", $time, what, got, exp);
            errors++;
            test_bad = 1'b1;
        end
    endtask

    // inactive request fields must read as zero
    task automatic check_outputs(input int idx, input trace_line_t t);
        logic w;
        logic r;
        logic s;
        logic j;
        w = t.flags[0];
        r = t.flags[1];
        s = t.flags[2];
        j = t.flags[3];
        test_bad = 1'b0;
        check_bit("reg_w_en", reg_w_en, w);
        check_reg("reg_w_rd", reg_w_rd, w ? t.exp_rd : '0);
        check_word("reg_w_data", reg_w_data, w ? t.exp_data : '0);
        check_bit("mem_r_en", mem_r_en, r);
        check_reg("mem_r_rd", mem_r_rd, r ? t.exp_rd : '0);
        check_word("mem_r_addr", mem_r_addr, r ? t.exp_addr : '0);
        check_strb("mem_r_strb", mem_r_strb, r ? t.exp_strb : '0);
        check_bit("mem_r_signed", mem_r_signed, t.flags[4]);
        check_bit("mem_w_en", mem_w_en, s);
        check_word("mem_w_addr", mem_w_addr, s ? t.exp_addr : '0);
        check_strb("mem_w_strb", mem_w_strb, s ? t.exp_strb : '0);
        check_word("mem_w_data", mem_w_data, s ? t.exp_data : '0);
        check_bit("jmp_do", jmp_do, j);
        check_word("jmp_pc", jmp_pc, j ? t.exp_addr : '0);
        if (test_bad) begin
            failed_tests++;
            $display("test %0d failed", idx);
        end else begin
            $display("test %0d ok", idx);
        end
    endtask

    task automatic run_test(input int idx, input trace_line_t t);
        @(posedge CLK);
        #DRIVE_DLY;
        flush    = t.ctl[0];
        stall    = t.ctl[1];
        mem_wait = t.ctl[2];
        pc       = t.pc;
        opcode   = t.opcode;
        funct3   = t.funct3;
        funct7   = t.funct7;
        rd_addr  = t.rd;
        rs1_data = t.rs1;
        rs2_data = t.rs2;
        imm      = t.imm;
        @(posedge CLK);         // captured here
        @(negedge CLK);
        check_outputs(idx, t);
    endtask

    initial begin
        trace_line_t idle;
        idle     = '{default: '0};
        rst_n    = 1'b0;
        flush    = 1'b0;
        stall    = 1'b0;
        mem_wait = 1'b0;
        pc       = '0;
        opcode   = OPC_JAL;     // live jal, only reset keeps it out
        funct3   = '0;
        funct7   = '0;
        rd_addr  = '0;
        rs1_data = '0;
        rs2_data = '0;
        imm      = '0;
        load_trace();
        cycle_limit = trace.size() * 4 + 20;
        repeat (RESET_CYC - 1) @(posedge CLK);
        @(negedge CLK);
        check_outputs(0, idle); // all requests low in reset
        @(posedge CLK);
        #DRIVE_DLY;
        rst_n = 1'b1;
        foreach (trace[i]) begin
            run_test(i + 1, trace[i]);
        end
        $display("tests %0d, failed %0d, errors %0d", trace.size() + 1, failed_tests, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* bench/exec_trace.txt */
# ctl(mem_wait,stall,flush) pc opcode funct3 funct7 rd rs1 rs2 imm, all hex
# expected: flags(signed,jmp,mem_w,mem_r,reg_w) rd data addr strb
0 00000100 33 0 00 05 00000007 00000003 00000000 01 05 0000000a 00000000 0
0 00000104 33 0 20 06 00000003 00000007 00000000 01 06 fffffffc 00000000 0
0 00000108 33 7 00 07 f0f0f0f0 ff00ff00 00000000 01 07 f000f000 00000000 0
0 0000010c 33 6 00 08 f0f0f0f0 0f0f0000 00000000 01 08 fffff0f0 00000000 0
0 00000110 33 4 00 09 aaaa5555 ffff0000 00000000 01 09 55555555 00000000 0
0 00000114 33 1 00 0a 00000001 00000024 00000000 01 0a 00000010 00000000 0
0 00000118 33 5 00 0b 80000000 00000004 00000000 01 0b 08000000 00000000 0
0 0000011c 33 5 20 0c 80000000 00000004 00000000 01 0c f8000000 00000000 0
0 00000120 33 2 00 0d ffffffff 00000001 00000000 01 0d 00000001 00000000 0
0 00000124 33 3 00 0e ffffffff 00000001 00000000 01 0e 00000000 00000000 0
0 00000128 13 0 00 0f 00000100 12345678 00000ff0 01 0f 000000f0 00000000 0
0 0000012c 13 3 00 10 00000005 00000000 00000fff 01 10 00000001 00000000 0
0 00000130 13 5 20 11 80000010 00000000 00000404 01 11 f8000001 00000000 0
0 00000134 37 0 00 12 00000000 00000000 12345fff 01 12 12345000 00000000 0
0 00002000 17 0 00 13 00000000 00000000 fffff000 01 13 00001000 00000000 0
0 00003000 6f 0 00 01 00000000 00000000 00000800 09 01 00003004 00003800 0
0 00003000 6f 0 00 02 00000000 00000000 00001ff0 09 02 00003004 00002ff0 0
0 00004000 67 0 00 01 00005001 00000000 00000004 09 01 00004004 00005004 0
0 00004100 67 0 00 03 00006000 00000000 00000ffd 09 03 00004104 00005ffc 0
0 00007000 63 0 00 00 00000042 00000042 00000010 08 00 00000000 00007010 0
0 00007000 63 0 00 00 ffffffff 00000001 00000010 00 00 00000000 00000000 0
0 00007000 63 1 00 00 ffffffff 00000001 00001ff8 08 00 00000000 00006ff8 0
0 00007000 63 1 00 00 00000042 00000042 00000010 00 00 00000000 00000000 0
0 00007000 63 4 00 00 ffffffff 00000001 00000010 08 00 00000000 00007010 0
0 00007000 63 4 00 00 00000001 ffffffff 00000010 00 00 00000000 00000000 0
0 00007000 63 5 00 00 00000001 ffffffff 00000010 08 00 00000000 00007010 0
0 00007000 63 5 00 00 ffffffff 00000001 00000010 00 00 00000000 00000000 0
0 00007000 63 6 00 00 00000001 ffffffff 00000010 08 00 00000000 00007010 0
0 00007000 63 6 00 00 ffffffff 00000001 00000010 00 00 00000000 00000000 0
0 00007000 63 7 00 00 ffffffff 00000001 00000010 08 00 00000000 00007010 0
0 00007000 63 7 00 00 00000001 ffffffff 00000010 00 00 00000000 00000000 0
0 00000200 03 0 00 04 00008000 00000000 00000ffc 12 04 00000000 00007ffc 1
0 00000204 03 5 00 07 00008000 00000000 00000006 02 07 00000000 00008006 3
0 00000208 03 1 00 06 00008000 00000000 00000002 12 06 00000000 00008002 3
0 0000020c 03 2 00 08 00008000 00000000 00000008 02 08 00000000 00008008 f
0 00000210 23 0 00 00 00009000 deadbeef 00000003 04 00 deadbeef 00009003 1
0 00000214 23 1 00 00 00009000 0000beef 00000ffe 04 00 0000beef 00008ffe 3
0 00000218 23 2 00 00 00009000 cafef00d 00000010 04 00 cafef00d 00009010 f
2 00000300 33 0 00 05 00000001 00000001 00000000 00 00 00000000 00000000 0
1 00003000 6f 0 00 01 00000000 00000000 00000800 00 00 00000000 00000000 0
0 00000304 33 0 00 1b 00000011 00000022 00000000 01 1b 00000033 00000000 0
4 00000308 23 2 00 00 0000a000 11223344 00000004 01 1b 00000033 00000000 0
4 0000030c 6f 0 00 01 00000000 00000000 00000800 01 1b 00000033 00000000 0
0 00000308 23 2 00 00 0000a000 11223344 00000004 04 00 11223344 0000a004 f
0 00000310 73 1 00 05 00000001 00000002 00000300 00 00 00000000 00000000 0
0 00000314 33 0 01 06 00000003 00000004 00000000 00 00 00000000 00000000 0
0 00000318 0f 0 00 00 00000000 00000000 00000000 00 00 00000000 00000000 0

/* common/exec_pkg.sv */
package exec_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int STRB_W     = 4;
    localparam int SHAMT_W    = 5;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [STRB_W-1:0]     strb_t;

    localparam word_t LINK_OFFSET = 32'd4;     // return address step

    localparam strb_t STRB_BYTE = 4'b0001;
    localparam strb_t STRB_HALF = 4'b0011;
    localparam strb_t STRB_WORD = 4'b1111;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;  // sub, sra, srai

    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b0000011,
        OPC_OP_IMM = 7'b0010011,
        OPC_AUIPC  = 7'b0010111,
        OPC_STORE  = 7'b0100011,
        OPC_OP     = 7'b0110011,
        OPC_LUI    = 7'b0110111,
        OPC_BRANCH = 7'b1100011,
        OPC_JALR   = 7'b1100111,
        OPC_JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [5:0] {
        OP_NONE,
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLL,
        OP_SRL,
        OP_SRA,
        OP_SLT,
        OP_SLTU,
        OP_LUI,
        OP_AUIPC,
        OP_JAL,
        OP_JALR,
        OP_BEQ,
        OP_BNE,
        OP_BLT,
        OP_BGE,
        OP_BLTU,
        OP_BGEU,
        OP_LB,
        OP_LBU,
        OP_LH,
        OP_LHU,
        OP_LW,
        OP_SB,
        OP_SH,
        OP_SW
    } exec_op_e;

endpackage

/* exec_stage.f */
common/exec_pkg.sv
verilog/exec_decode.sv
verilog/exec_alu.sv
verilog/exec_branch.sv
verilog/exec_lsu.sv
verilog/exec_stage.sv
bench/exec_stage_props.sv
bench/exec_stage_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the exec_stage testbench with Verilator, run it, then scan the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module exec_stage_tb -Mdir obj_dir -o exec_stage_sim \
    -f exec_stage.f > sim.log 2>&1 \
    && ./obj_dir/exec_stage_sim >> sim.log 2>&1 \
    || echo "RESULT: FAIL" >> sim.log
cat sim.log
grep -q "RESULT: FAIL" sim.log && exit 1 || exit 0

/* verilog/exec_alu.sv */
`timescale 1ns/1ps

module exec_alu import exec_pkg::*; (
    input  exec_op_e           op,
    input  word_t              pc,
    input  word_t              rs1_data,
    input  word_t              rs2_data,
    input  word_t              imm_i,
    input  logic [SHAMT_W-1:0] shamt,
    input  reg_addr_t          rd_addr,
    output logic               reg_w_en,
    output reg_addr_t          reg_w_rd,
    output word_t              reg_w_data
);

    logic  wr;
    word_t res;
    logic  lt_s;
    logic  lt_u;

    assign lt_s = $signed(rs1_data) < $signed(rs2_data);
    assign lt_u = rs1_data < rs2_data;

    always_comb begin
        wr  = 1'b1;
        res = '0;
        case (op)
            OP_ADD:   res = rs1_data + rs2_data;
            OP_SUB:   res = rs1_data - rs2_data;
            OP_AND:   res = rs1_data & rs2_data;
            OP_OR:    res = rs1_data | rs2_data;
            OP_XOR:   res = rs1_data ^ rs2_data;
            OP_SLL:   res = rs1_data << shamt;
            OP_SRL:   res = rs1_data >> shamt;
            OP_SRA:   res = $signed(rs1_data) >>> shamt;   // keeps sign bit
            OP_SLT:   res = {{(XLEN-1){1'b0}}, lt_s};
            OP_SLTU:  res = {{(XLEN-1){1'b0}}, lt_u};
            OP_LUI:   res = imm_i;
            OP_AUIPC: res = pc + imm_i;
            OP_JAL,
            OP_JALR:  res = pc + LINK_OFFSET;  // link value
            default:  wr  = 1'b0;             // loads write back in mem stage
        endcase
    end

    assign reg_w_en   = wr;
    assign reg_w_rd   = wr ? rd_addr : '0;
    assign reg_w_data = res;

endmodule

/* verilog/exec_branch.sv */
`timescale 1ns/1ps

module exec_branch import exec_pkg::*; (
    input  exec_op_e op,
    input  word_t    pc,
    input  word_t    rs1_data,
    input  word_t    rs2_data,
    input  word_t    imm_i,
    input  word_t    imm_b,
    output logic     jmp_do,
    output word_t    jmp_pc
);

    logic  take;
    word_t target;
    word_t jalr_sum;

    assign jalr_sum = rs1_data + imm_i;

    always_comb begin
        take   = 1'b0;
        target = pc + imm_b;
        case (op)
            OP_BEQ:  take = (rs1_data == rs2_data);
            OP_BNE:  take = (rs1_data != rs2_data);
            OP_BLT:  take = $signed(rs1_data) < $signed(rs2_data);
            OP_BGE:  take = $signed(rs1_data) >= $signed(rs2_data);
            OP_BLTU: take = rs1_data < rs2_data;
            OP_BGEU: take = rs1_data >= rs2_data;
            OP_JAL:  take = 1'b1;
            OP_JALR: begin
                take   = 1'b1;
                target = {jalr_sum[XLEN-1:1], 1'b0};   // lsb cleared
            end
            default: take = 1'b0;
        endcase
    end

    assign jmp_do = take;
    assign jmp_pc = take ? target : '0;

endmodule

/* verilog/exec_decode.sv */
`timescale 1ns/1ps

module exec_decode import exec_pkg::*; (
    input  logic               CLK,
    input  logic               rst_n,
    input  logic               flush,
    input  logic               stall,
    input  logic               mem_wait,
    input  word_t              pc,
    input  logic [6:0]         opcode,
    input  logic [2:0]         funct3,
    input  logic [6:0]         funct7,
    input  reg_addr_t          rd_addr,
    input  word_t              rs1_data,
    input  word_t              rs2_data,
    input  word_t              imm,
    output exec_op_e           op,
    output word_t              pc_q,
    output word_t              rs1_q,
    output word_t              rs2_q,
    output word_t              imm_i,
    output word_t              imm_b,
    output logic [SHAMT_W-1:0] shamt,
    output reg_addr_t          rd_q
);

    exec_op_e op_d;
    exec_op_e op_q;
    word_t    imm_q;
    word_t    imm_i_sext;
    word_t    opb_d;

    // shared by op and op-imm, funct3 picks the operation
    function automatic exec_op_e int_op(input logic [2:0] f3, input logic alt,
                                        input logic imm_form);
        exec_op_e r;
        case (f3)
            3'b000:  r = (alt && !imm_form) ? OP_SUB : OP_ADD;
            3'b001:  r = OP_SLL;
            3'b010:  r = OP_SLT;
            3'b011:  r = OP_SLTU;
            3'b100:  r = OP_XOR;
            3'b101:  r = alt ? OP_SRA : OP_SRL;
            3'b110:  r = OP_OR;
            default: r = OP_AND;
        endcase
        return r;
    endfunction

    always_comb begin
        op_d = OP_NONE;
        case (opcode)
            OPC_OP: begin
                if (funct7 == F7_BASE ||
                    (funct7 == F7_ALT && (funct3 == 3'b000 || funct3 == 3'b101))) begin
                    op_d = int_op(funct3, funct7[5], 1'b0);
                end
            end
            OPC_OP_IMM: begin
                if (funct3 == 3'b001) begin
                    op_d = (funct7 == F7_BASE) ? OP_SLL : OP_NONE;
                end else if (funct3 != 3'b101 || funct7 == F7_BASE || funct7 == F7_ALT) begin
                    op_d = int_op(funct3, funct7[5], 1'b1);
                end
            end
            OPC_LUI:   op_d = OP_LUI;
            OPC_AUIPC: op_d = OP_AUIPC;
            OPC_JAL:   op_d = OP_JAL;
            OPC_JALR:  op_d = (funct3 == 3'b000) ? OP_JALR : OP_NONE;
            OPC_BRANCH: begin
                case (funct3)
                    3'b000:  op_d = OP_BEQ;
                    3'b001:  op_d = OP_BNE;
                    3'b100:  op_d = OP_BLT;
                    3'b101:  op_d = OP_BGE;
                    3'b110:  op_d = OP_BLTU;
                    3'b111:  op_d = OP_BGEU;
                    default: op_d = OP_NONE;
                endcase
            end
            OPC_LOAD: begin
                case (funct3)
                    3'b000:  op_d = OP_LB;
                    3'b001:  op_d = OP_LH;
                    3'b010:  op_d = OP_LW;
                    3'b100:  op_d = OP_LBU;
                    3'b101:  op_d = OP_LHU;
                    default: op_d = OP_NONE;
                endcase
            end
            OPC_STORE: begin
                case (funct3)
                    3'b000:  op_d = OP_SB;
                    3'b001:  op_d = OP_SH;
                    3'b010:  op_d = OP_SW;
                    default: op_d = OP_NONE;
                endcase
            end
            default: op_d = OP_NONE;    // csr, fence, system
        endcase
    end

    // operand b is the immediate for op-imm forms
    assign opb_d = (opcode == OPC_OP_IMM) ? {{20{imm[11]}}, imm[11:0]} : rs2_data;

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            op_q <= OP_NONE;
        end else if (flush || stall) begin
            op_q <= OP_NONE;            // bubble
        end else if (!mem_wait) begin
            op_q <= op_d;
        end
    end

    always_ff @(posedge CLK) begin
        if (!flush && !stall && !mem_wait) begin
            pc_q  <= pc;
            rs1_q <= rs1_data;
            rs2_q <= opb_d;
            imm_q <= imm;
            rd_q  <= rd_addr;
        end
    end

    assign imm_i_sext = {{20{imm_q[11]}}, imm_q[11:0]};

    assign op    = op_q;
    assign imm_i = (op_q == OP_LUI || op_q == OP_AUIPC) ? {imm_q[31:12], 12'b0} : imm_i_sext;
    assign imm_b = {{19{imm_q[12]}}, imm_q[12:1], 1'b0};
    assign shamt = rs2_q[SHAMT_W-1:0]; // rs2 or imm[4:0]

endmodule

/* verilog/exec_lsu.sv */
`timescale 1ns/1ps

module exec_lsu import exec_pkg::*; (
    input  exec_op_e  op,
    input  word_t     rs1_data,
    input  word_t     rs2_data,
    input  word_t     imm_i,
    input  reg_addr_t rd_addr,
    output logic      mem_r_en,
    output reg_addr_t mem_r_rd,
    output word_t     mem_r_addr,
    output strb_t     mem_r_strb,
    output logic      mem_r_signed,
    output logic      mem_w_en,
    output word_t     mem_w_addr,
    output strb_t     mem_w_strb,
    output word_t     mem_w_data
);

    logic  rd_en;
    logic  wr_en;
    logic  sgn;
    strb_t strb;
    word_t addr;

    assign addr = rs1_data + imm_i;  // store offset also sits in imm_i

    always_comb begin
        rd_en = 1'b0;
        wr_en = 1'b0;
        sgn   = 1'b0;
        strb  = '0;
        case (op)
            OP_LB: begin
                rd_en = 1'b1;
                sgn   = 1'b1;
                strb  = STRB_BYTE;
            end
            OP_LBU: begin
                rd_en = 1'b1;
                strb  = STRB_BYTE;
            end
            OP_LH: begin
                rd_en = 1'b1;
                sgn   = 1'b1;
                strb  = STRB_HALF;
            end
            OP_LHU: begin
                rd_en = 1'b1;
                strb  = STRB_HALF;
            end
            OP_LW: begin
                rd_en = 1'b1;
                strb  = STRB_WORD;
            end
            OP_SB: begin
                wr_en = 1'b1;
                strb  = STRB_BYTE;
            end
            OP_SH: begin
                wr_en = 1'b1;
                strb  = STRB_HALF;
            end
            OP_SW: begin
                wr_en = 1'b1;
                strb  = STRB_WORD;
            end
            default: strb = '0;
        endcase
    end

    assign mem_r_en     = rd_en;
    assign mem_r_rd     = rd_en ? rd_addr : '0;
    assign mem_r_addr   = rd_en ? addr : '0;
    assign mem_r_strb   = rd_en ? strb : '0;
    assign mem_r_signed = sgn;

    assign mem_w_en   = wr_en;
    assign mem_w_addr = wr_en ? addr : '0;
    assign mem_w_strb = wr_en ? strb : '0;
    assign mem_w_data = wr_en ? rs2_data : '0;

endmodule

/* verilog/exec_stage.sv */
`timescale 1ns/1ps

module exec_stage import exec_pkg::*; (
    input  logic       CLK,
    input  logic       rst_n,
    input  logic       flush,
    input  logic       stall,
    input  logic       mem_wait,
    input  word_t      pc,
    input  logic [6:0] opcode,
    input  logic [2:0] funct3,
    input  logic [6:0] funct7,
    input  reg_addr_t  rd_addr,
    input  word_t      rs1_data,
    input  word_t      rs2_data,
    input  word_t      imm,
    output logic       reg_w_en,
    output reg_addr_t  reg_w_rd,
    output word_t      reg_w_data,
    output logic       mem_r_en,
    output reg_addr_t  mem_r_rd,
    output word_t      mem_r_addr,
    output strb_t      mem_r_strb,
    output logic       mem_r_signed,
    output logic       mem_w_en,
    output word_t      mem_w_addr,
    output strb_t      mem_w_strb,
    output word_t      mem_w_data,
    output logic       jmp_do,
    output word_t      jmp_pc
);

    exec_op_e           op;
    word_t              pc_q;
    word_t              rs1_q;
    word_t              rs2_q;
    word_t              imm_i;
    word_t              imm_b;
    logic [SHAMT_W-1:0] shamt;
    reg_addr_t          rd_q;

    exec_decode i_exec_decode (
        .CLK      (CLK),
        .rst_n    (rst_n),
        .flush    (flush),
        .stall    (stall),
        .mem_wait (mem_wait),
        .pc       (pc),
        .opcode   (opcode),
        .funct3   (funct3),
        .funct7   (funct7),
        .rd_addr  (rd_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .imm      (imm),
        .op       (op),
        .pc_q     (pc_q),
        .rs1_q    (rs1_q),
        .rs2_q    (rs2_q),
        .imm_i    (imm_i),
        .imm_b    (imm_b),
        .shamt    (shamt),
        .rd_q     (rd_q)
    );

    exec_alu i_exec_alu (
        .op         (op),
        .pc         (pc_q),
        .rs1_data   (rs1_q),
        .rs2_data   (rs2_q),
        .imm_i      (imm_i),
        .shamt      (shamt),
        .rd_addr    (rd_q),
        .reg_w_en   (reg_w_en),
        .reg_w_rd   (reg_w_rd),
        .reg_w_data (reg_w_data)
    );

    exec_branch i_exec_branch (
        .op       (op),
        .pc       (pc_q),
        .rs1_data (rs1_q),
        .rs2_data (rs2_q),
        .imm_i    (imm_i),
        .imm_b    (imm_b),
        .jmp_do   (jmp_do),
        .jmp_pc   (jmp_pc)
    );

    exec_lsu i_exec_lsu (
        .op           (op),
        .rs1_data     (rs1_q),
        .rs2_data     (rs2_q),
        .imm_i        (imm_i),
        .rd_addr      (rd_q),
        .mem_r_en     (mem_r_en),
        .mem_r_rd     (mem_r_rd),
        .mem_r_addr   (mem_r_addr),
        .mem_r_strb   (mem_r_strb),
        .mem_r_signed (mem_r_signed),
        .mem_w_en     (mem_w_en),
        .mem_w_addr   (mem_w_addr),
        .mem_w_strb   (mem_w_strb),
        .mem_w_data   (mem_w_data)
    );

endmodule
